// File: logic/alu_pkg.sv
package alu_pkg;

   typedef enum logic [1:0] {
      OP_ADD = 2'd0,
      OP_SUB = 2'd1,
      OP_MUL = 2'd2,
      OP_DIV = 2'd3
   } alu_op_e;

   typedef enum logic [2:0] {
      ST_IDLE    = 3'd0,
      ST_SIGN_B  = 3'd1,
      ST_MUL     = 3'd2,
      ST_DIV_R   = 3'd3,
      ST_DIV_CMP = 3'd4,
      ST_DIV_CNT = 3'd5,
      ST_SIGN_Q  = 3'd6,
      ST_FINISH  = 3'd7
   } alu_state_e;

   // Word addresses on the bus.
   localparam logic [2:0] REG_A      = 3'd0;
   localparam logic [2:0] REG_B      = 3'd1;
   localparam logic [2:0] REG_CMD    = 3'd2;
   localparam logic [2:0] REG_STATUS = 3'd3;
   localparam logic [2:0] REG_RESULT = 3'd4;

   localparam int STAT_BUSY = 0;
   localparam int STAT_DONE = 1;
   localparam int STAT_OVF  = 2;
   localparam int STAT_ZERO = 3;

endpackage

// File: logic/alu_ctrl_if.sv
`timescale 1ns/1ps
interface alu_ctrl_if;

   alu_pkg::alu_state_e state;
   alu_pkg::alu_op_e    op;
   logic                load;       // Start of an operation.
   logic                neg;        // Adder computes a - b.

   logic                ovf;        // Carry in MUL, signed overflow elsewhere.
   logic                sign;       // Top bit of the adder result.
   logic                a_neg;
   logic                b_neg;
   logic                b_zero;
   logic                mul_empty;  // Multiplier has no bits left above bit 0.
   logic                mul_top;    // Next shift of B loses a bit.

   modport seq (
      output state, op, load, neg,
      input  ovf, sign, a_neg, b_neg, b_zero, mul_empty, mul_top
   );

   modport dp (
      input  state, op, load, neg,
      output ovf, sign, a_neg, b_neg, b_zero, mul_empty, mul_top
   );

endinterface

// File: logic/alu_wb_regs.sv
`timescale 1ns/1ps
module alu_wb_regs #(
   parameter int DATA_WIDTH = 16
) (
   input  logic                  i_clk,
   input  logic                  i_nrst,
   input  logic                  i_wb_cyc,
   input  logic                  i_wb_stb,
   input  logic                  i_wb_we,
   input  logic [2:0]            i_wb_adr,
   input  logic [DATA_WIDTH-1:0] i_wb_dat,
   output logic [DATA_WIDTH-1:0] o_wb_dat,
   output logic                  o_wb_ack,
   input  logic                  i_done,
   input  logic                  i_ovf,
   input  logic                  i_zero,
   input  logic [DATA_WIDTH-1:0] i_result,
   output logic                  o_start,
   output alu_pkg::alu_op_e      o_op,
   output logic [DATA_WIDTH-1:0] o_a,
   output logic [DATA_WIDTH-1:0] o_b,
   output logic                  o_irq
);

   logic                  req;
   logic                  busy;
   logic                  done;
   logic                  ovf;
   logic                  zero;
   logic [DATA_WIDTH-1:0] result;
   logic [DATA_WIDTH-1:0] status;

   assign req   = i_wb_cyc & i_wb_stb & ~o_wb_ack;  // One ack per request.
   assign o_irq = done;

   always_comb begin
      status                     = '0;
      status[alu_pkg::STAT_BUSY] = busy;
      status[alu_pkg::STAT_DONE] = done;
      status[alu_pkg::STAT_OVF]  = ovf;
      status[alu_pkg::STAT_ZERO] = zero;
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         o_wb_ack <= 1'b0;
         o_wb_dat <= '0;
         o_start  <= 1'b0;
         o_op     <= alu_pkg::OP_ADD;
         o_a      <= '0;
         o_b      <= '0;
         busy     <= 1'b0;
         done     <= 1'b0;
         ovf      <= 1'b0;
         zero     <= 1'b0;
         result   <= '0;
      end else begin
         o_wb_ack <= req;
         o_start  <= 1'b0;
         if (req && i_wb_we) begin
            case (i_wb_adr)
               alu_pkg::REG_A: o_a <= i_wb_dat;
               alu_pkg::REG_B: o_b <= i_wb_dat;
               alu_pkg::REG_CMD: if (!busy) begin
                  o_op    <= alu_pkg::alu_op_e'(i_wb_dat[1:0]);
                  o_start <= 1'b1;
                  busy    <= 1'b1;
                  done    <= 1'b0;
                  ovf     <= 1'b0;
                  zero    <= 1'b0;
               end
               default: ;
            endcase
         end
         if (req && !i_wb_we) begin
            case (i_wb_adr)
               alu_pkg::REG_A:      o_wb_dat <= o_a;
               alu_pkg::REG_B:      o_wb_dat <= o_b;
               alu_pkg::REG_CMD:    o_wb_dat <= DATA_WIDTH'(o_op);
               alu_pkg::REG_STATUS: o_wb_dat <= status;
               alu_pkg::REG_RESULT: o_wb_dat <= result;
               default:             o_wb_dat <= '0;
            endcase
         end
         if (i_done) begin
            busy   <= 1'b0;
            done   <= 1'b1;
            ovf    <= i_ovf;
            zero   <= i_zero;
            result <= (i_ovf | i_zero) ? '0 : i_result;  // Errors read as 0.
         end
      end
   end

   done_while_busy: assert property (@(posedge i_clk) disable iff (!i_nrst)
      i_done |-> busy);

endmodule

// File: logic/alu_sequencer.sv
`timescale 1ns/1ps
module alu_sequencer #(
   parameter int DATA_WIDTH = 16
) (
   input  logic             i_clk,
   input  logic             i_nrst,
   input  logic             i_start,
   input  alu_pkg::alu_op_e i_op,
   input  logic             i_last,
   alu_ctrl_if.seq          ctrl,
   output logic             o_cnt_clr,
   output logic             o_cnt_adv,
   output logic             o_done,
   output logic             o_ovf,
   output logic             o_zero
);

   alu_pkg::alu_state_e state;
   alu_pkg::alu_state_e next_md;
   logic                muldiv;
   logic                neg_q;    // Result needs a final negate.
   logic                q_top;    // Top bit of the unsigned product.

   assign muldiv     = (i_op == alu_pkg::OP_MUL) | (i_op == alu_pkg::OP_DIV);
   assign next_md    = (i_op == alu_pkg::OP_MUL) ? alu_pkg::ST_MUL : alu_pkg::ST_DIV_R;
   assign ctrl.state = state;
   assign ctrl.op    = i_op;
   assign ctrl.load  = (state == alu_pkg::ST_IDLE) & i_start;
   assign o_cnt_clr  = ctrl.load;
   assign o_cnt_adv  = (state == alu_pkg::ST_DIV_CNT) & ~i_last;
   assign o_done     = (state == alu_pkg::ST_FINISH);

   always_comb begin
      case (state)
         alu_pkg::ST_IDLE:    ctrl.neg = (i_op == alu_pkg::OP_SUB) | (muldiv & ctrl.a_neg);
         alu_pkg::ST_SIGN_B,
         alu_pkg::ST_DIV_CMP,
         alu_pkg::ST_SIGN_Q:  ctrl.neg = 1'b1;
         default:             ctrl.neg = 1'b0;
      endcase
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state  <= alu_pkg::ST_IDLE;
         neg_q  <= 1'b0;
         q_top  <= 1'b0;
         o_ovf  <= 1'b0;
         o_zero <= 1'b0;
      end else begin
         case (state)
            alu_pkg::ST_IDLE: if (i_start) begin
               o_ovf  <= 1'b0;
               o_zero <= 1'b0;
               q_top  <= 1'b0;
               neg_q  <= ctrl.a_neg ^ ctrl.b_neg;
               if (!muldiv) begin
                  o_ovf <= ctrl.ovf;
                  state <= alu_pkg::ST_FINISH;
               end else if ((i_op == alu_pkg::OP_DIV) && ctrl.b_zero) begin
                  o_zero <= 1'b1;
                  state  <= alu_pkg::ST_FINISH;
               end else if (ctrl.ovf) begin                // A is the most negative value.
                  o_ovf <= 1'b1;
                  state <= alu_pkg::ST_FINISH;
               end else begin
                  state <= ctrl.b_neg ? alu_pkg::ST_SIGN_B : next_md;
               end
            end
            alu_pkg::ST_SIGN_B: begin
               o_ovf <= ctrl.ovf;
               state <= ctrl.ovf ? alu_pkg::ST_FINISH : next_md;
            end
            alu_pkg::ST_MUL: begin
               if (ctrl.ovf || (ctrl.mul_top && !ctrl.mul_empty)) begin
                  o_ovf <= 1'b1;
                  state <= alu_pkg::ST_FINISH;
               end else if (ctrl.mul_empty) begin
                  q_top <= ctrl.sign;
                  if (neg_q) begin
                     state <= alu_pkg::ST_SIGN_Q;
                  end else begin
                     o_ovf <= ctrl.sign;
                     state <= alu_pkg::ST_FINISH;
                  end
               end
            end
            alu_pkg::ST_DIV_R:   state <= alu_pkg::ST_DIV_CMP;
            alu_pkg::ST_DIV_CMP: state <= alu_pkg::ST_DIV_CNT;
            alu_pkg::ST_DIV_CNT: if (i_last) begin
               state <= neg_q ? alu_pkg::ST_SIGN_Q : alu_pkg::ST_FINISH;
            end else begin
               state <= alu_pkg::ST_DIV_R;
            end
            alu_pkg::ST_SIGN_Q: begin
               o_ovf <= q_top & ~ctrl.sign;  // Magnitude above 2**(W-1).
               state <= alu_pkg::ST_FINISH;
            end
            default: state <= alu_pkg::ST_IDLE;
         endcase
      end
   end

   start_in_idle: assert property (@(posedge i_clk) disable iff (!i_nrst)
      i_start |-> state == alu_pkg::ST_IDLE);

endmodule

// File: logic/alu_step_counter.sv
`timescale 1ns/1ps
module alu_step_counter #(
   parameter int DATA_WIDTH = 16
) (
   input  logic i_clk,
   input  logic i_nrst,
   input  logic i_clr,
   input  logic i_adv,
   output logic o_last
);

   localparam int CW = $clog2(DATA_WIDTH);

   logic [CW-1:0] cnt;

   assign o_last = (cnt == CW'(DATA_WIDTH - 1));

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         cnt <= '0;
      end else if (i_clr) begin
         cnt <= '0;
      end else if (i_adv) begin
         cnt <= cnt + 1'b1;
      end
   end

   no_wrap: assert property (@(posedge i_clk) disable iff (!i_nrst)
      i_adv && !i_clr |-> !o_last);

endmodule

// File: logic/alu_datapath.sv
`timescale 1ns/1ps
module alu_datapath #(
   parameter int DATA_WIDTH = 16
) (
   input  logic                  i_clk,
   input  logic                  i_nrst,
   input  logic [DATA_WIDTH-1:0] i_a,
   input  logic [DATA_WIDTH-1:0] i_b,
   alu_ctrl_if.dp                ctrl,
   output logic [DATA_WIDTH-1:0] o_result
);

   logic [DATA_WIDTH-1:0] a;
   logic [DATA_WIDTH-1:0] b;
   logic [DATA_WIDTH-1:0] r;
   logic [DATA_WIDTH-1:0] q;
   logic [DATA_WIDTH-1:0] add_a;
   logic [DATA_WIDTH-1:0] add_b;
   logic [DATA_WIDTH-1:0] b_eff;
   logic [DATA_WIDTH-1:0] sum;
   logic                  carry;
   logic                  sovf;
   logic                  arith;

   assign arith = (ctrl.op == alu_pkg::OP_ADD) | (ctrl.op == alu_pkg::OP_SUB);

   always_comb begin
      add_a = '0;
      add_b = '0;
      case (ctrl.state)
         alu_pkg::ST_IDLE: begin
            add_a = arith ? i_a : '0;  // Negates A for multiply and divide.
            add_b = arith ? i_b : i_a;
         end
         alu_pkg::ST_SIGN_B:  add_b = b;
         alu_pkg::ST_MUL: begin
            add_a = q;
            add_b = a[0] ? b : '0;
         end
         alu_pkg::ST_DIV_CMP: begin
            add_a = r;
            add_b = b;
         end
         alu_pkg::ST_SIGN_Q:  add_b = q;
         default: ;
      endcase
   end

   assign b_eff        = add_b ^ {DATA_WIDTH{ctrl.neg}};
   assign {carry, sum} = {1'b0, add_a} + {1'b0, b_eff} + (DATA_WIDTH + 1)'(ctrl.neg);
   assign sovf = (add_a[DATA_WIDTH-1] == b_eff[DATA_WIDTH-1]) &
                 (sum[DATA_WIDTH-1] != add_a[DATA_WIDTH-1]);

   assign ctrl.ovf       = (ctrl.state == alu_pkg::ST_MUL) ? carry : sovf;
   assign ctrl.sign      = sum[DATA_WIDTH-1];
   assign ctrl.a_neg     = i_a[DATA_WIDTH-1];
   assign ctrl.b_neg     = i_b[DATA_WIDTH-1];
   assign ctrl.b_zero    = (i_b == '0);
   assign ctrl.mul_empty = (a[DATA_WIDTH-1:1] == '0);
   assign ctrl.mul_top   = b[DATA_WIDTH-1];
   assign o_result       = q;

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         a <= '0;
         b <= '0;
         r <= '0;
         q <= '0;
      end else begin
         case (ctrl.state)
            alu_pkg::ST_IDLE: if (ctrl.load) begin
               a <= sum;
               b <= i_b;
               r <= '0;
               q <= arith ? sum : '0;
            end
            alu_pkg::ST_SIGN_B: b <= sum;
            alu_pkg::ST_MUL: begin
               q <= sum;
               a <= a >> 1;
               b <= b << 1;
            end
            alu_pkg::ST_DIV_R: begin
               r <= {r[DATA_WIDTH-2:0], a[DATA_WIDTH-1]};
               a <= a << 1;
            end
            alu_pkg::ST_DIV_CMP: begin
               if (carry) r <= sum;  // No borrow, so R >= B.
               q <= {q[DATA_WIDTH-2:0], carry};
            end
            alu_pkg::ST_SIGN_Q: q <= sum;
            default: ;
         endcase
      end
   end

endmodule

// File: logic/alu_wb_top.sv
`timescale 1ns/1ps
module alu_wb_top #(
   parameter int DATA_WIDTH = 16
) (
   input  logic                  i_clk,
   input  logic                  i_nrst,
   input  logic                  i_wb_cyc,
   input  logic                  i_wb_stb,
   input  logic                  i_wb_we,
   input  logic [2:0]            i_wb_adr,
   input  logic [DATA_WIDTH-1:0] i_wb_dat,
   output logic [DATA_WIDTH-1:0] o_wb_dat,
   output logic                  o_wb_ack,
   output logic                  o_irq
);

   logic                  start, done, ovf, zero, last, cnt_clr, cnt_adv;
   alu_pkg::alu_op_e      op;
   logic [DATA_WIDTH-1:0] a, b, result;

   alu_ctrl_if ctrl ();

   alu_wb_regs #(.DATA_WIDTH(DATA_WIDTH)) u_regs (
      .i_clk(i_clk), .i_nrst(i_nrst),
      .i_wb_cyc(i_wb_cyc), .i_wb_stb(i_wb_stb), .i_wb_we(i_wb_we),
      .i_wb_adr(i_wb_adr), .i_wb_dat(i_wb_dat), .o_wb_dat(o_wb_dat), .o_wb_ack(o_wb_ack),
      .i_done(done), .i_ovf(ovf), .i_zero(zero), .i_result(result),
      .o_start(start), .o_op(op), .o_a(a), .o_b(b), .o_irq(o_irq)
   );

   alu_sequencer #(.DATA_WIDTH(DATA_WIDTH)) u_seq (
      .i_clk(i_clk), .i_nrst(i_nrst), .i_start(start), .i_op(op), .i_last(last),
      .ctrl(ctrl.seq), .o_cnt_clr(cnt_clr), .o_cnt_adv(cnt_adv),
      .o_done(done), .o_ovf(ovf), .o_zero(zero)
   );

   alu_step_counter #(.DATA_WIDTH(DATA_WIDTH)) u_cnt (
      .i_clk(i_clk), .i_nrst(i_nrst), .i_clr(cnt_clr), .i_adv(cnt_adv), .o_last(last)
   );

   alu_datapath #(.DATA_WIDTH(DATA_WIDTH)) u_dp (
      .i_clk(i_clk), .i_nrst(i_nrst), .i_a(a), .i_b(b), .ctrl(ctrl.dp), .o_result(result)
   );

endmodule

// File: verification/alu_wb_tb.sv
`timescale 1ns/1ps
module alu_wb_tb;

   localparam int W = 16;
   localparam int TIMEOUT = 200;
   localparam logic [W-1:0] MIN_VAL = {1'b1, {(W-1){1'b0}}};
   localparam logic [W-1:0] MAX_VAL = ~MIN_VAL;
   localparam longint SMAX = (longint'(1) <<< (W - 1)) - 1;
   localparam longint SMIN = -SMAX - 1;

   logic         clk;
   logic         nrst;
   logic         wb_cyc;
   logic         wb_stb;
   logic         wb_we;
   logic [2:0]   wb_adr;
   logic [W-1:0] wb_wdat;
   logic [W-1:0] wb_rdat;
   logic         wb_ack;
   logic         irq;
   logic         chk_en;     // Read data is compared on the ack cycle.
   logic [W-1:0] chk_exp;
   string        chk_name;
   logic [31:0]  rng;
   int           errors;
   int           timeouts;

   alu_wb_top #(.DATA_WIDTH(W)) DUT (
      .i_clk(clk), .i_nrst(nrst),
      .i_wb_cyc(wb_cyc), .i_wb_stb(wb_stb), .i_wb_we(wb_we),
      .i_wb_adr(wb_adr), .i_wb_dat(wb_wdat), .o_wb_dat(wb_rdat), .o_wb_ack(wb_ack),
      .o_irq(irq)
   );

   always #4 clk = ~clk;

   read_matches: assert property (@(posedge clk) disable iff (!nrst)
      wb_ack && chk_en |-> wb_rdat == chk_exp)
      else begin
         errors = errors + 1;
         $display("Fail %s expected %h actual %h", chk_name, $sampled(chk_exp),
                  $sampled(wb_rdat));
      end

   ack_one_cycle: assert property (@(posedge clk) disable iff (!nrst)
      wb_ack |=> !wb_ack)
      else begin
         errors = errors + 1;
         $display("Wishbone ack stayed high for more than one cycle");
      end

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic [W-1:0] sext_byte(input logic [W-1:0] v);
      return {{(W-8){v[7]}}, v[7:0]};
   endfunction

   // Exact signed arithmetic, then range and error rules.
   function automatic void model_op(input alu_pkg::alu_op_e op, input logic [W-1:0] a,
                                    input logic [W-1:0] b, output logic [W-1:0] res,
                                    output logic ovf, output logic zero);
      longint sa;
      longint sb;
      longint exact;
      sa = longint'($signed(a));
      sb = longint'($signed(b));
      ovf = 1'b0;
      zero = 1'b0;
      exact = 0;
      case (op)
         alu_pkg::OP_ADD: exact = sa + sb;
         alu_pkg::OP_SUB: exact = sa - sb;
         alu_pkg::OP_MUL: begin
            ovf = (a == MIN_VAL) || (b == MIN_VAL);
            exact = sa * sb;
         end
         default: begin
            if (b == '0) begin
               zero = 1'b1;
            end else if (a == MIN_VAL || b == MIN_VAL) begin
               ovf = 1'b1;
            end else begin
               exact = (sa < 0 ? -sa : sa) / (sb < 0 ? -sb : sb);  // Truncates toward zero.
               if ((sa < 0) != (sb < 0)) exact = -exact;
            end
         end
      endcase
      if (exact > SMAX || exact < SMIN) ovf = 1'b1;
      res = (ovf || zero) ? '0 : exact[W-1:0];
   endfunction

   task automatic finish_run();
      $display("Checks failed: %0d, timeouts: %0d", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   endtask

   task automatic next_rand(output logic [W-1:0] v);
      rng = xorshift(rng);
      v = rng[W-1:0];
   endtask

   task automatic wait_ack();
      int n;
      n = 0;
      do begin
         @(posedge clk);
         n++;
      end while (!wb_ack && n < TIMEOUT);
      if (!wb_ack) begin
         timeouts++;
         $display("Timeout: no Wishbone ack within %0d cycles", TIMEOUT);
         finish_run();
      end
   endtask

   task automatic bus_write(input logic [2:0] adr, input logic [W-1:0] dat);
      @(posedge clk);
      wb_cyc  <= 1'b1;
      wb_stb  <= 1'b1;
      wb_we   <= 1'b1;
      wb_adr  <= adr;
      wb_wdat <= dat;
      wait_ack();
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we  <= 1'b0;
   endtask

   task automatic bus_read(input logic [2:0] adr, input logic check, input logic [W-1:0] exp,
                           input string name, output logic [W-1:0] data);
      @(posedge clk);
      wb_cyc   <= 1'b1;
      wb_stb   <= 1'b1;
      wb_we    <= 1'b0;
      wb_adr   <= adr;
      chk_en   <= check;
      chk_exp  <= exp;
      chk_name = name;
      wait_ack();
      data = wb_rdat;
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      chk_en <= 1'b0;
   endtask

   task automatic check_irq(input string name, input logic exp);
      assert (irq == exp) else begin
         errors = errors + 1;
         $display("Fail %s irq expected %0b actual %0b", name, exp, irq);
      end
   endtask

   task automatic wait_done();
      logic [W-1:0] st;
      int n;
      st = '0;
      n = 0;
      while (!st[alu_pkg::STAT_DONE] && n < TIMEOUT) begin
         bus_read(alu_pkg::REG_STATUS, 1'b0, '0, "poll", st);
         n++;
      end
      if (!st[alu_pkg::STAT_DONE]) begin
         timeouts++;
         $display("Timeout: operation did not finish within %0d status polls", TIMEOUT);
         finish_run();
      end
   endtask

   task automatic start_op(input string name, input alu_pkg::alu_op_e op,
                           input logic [W-1:0] a, input logic [W-1:0] b);
      bus_write(alu_pkg::REG_A, a);
      bus_write(alu_pkg::REG_B, b);
      bus_write(alu_pkg::REG_CMD, {{(W-2){1'b0}}, op});
      check_irq({name, " start"}, 1'b0);  // Command write clears the interrupt.
   endtask

   task automatic check_op(input string name, input alu_pkg::alu_op_e op,
                           input logic [W-1:0] a, input logic [W-1:0] b);
      logic [W-1:0] res;
      logic         ovf;
      logic         zero;
      logic [W-1:0] status;
      logic [W-1:0] rd;
      wait_done();
      model_op(op, a, b, res, ovf, zero);
      status = '0;
      status[alu_pkg::STAT_DONE] = 1'b1;
      status[alu_pkg::STAT_OVF]  = ovf;
      status[alu_pkg::STAT_ZERO] = zero;
      bus_read(alu_pkg::REG_STATUS, 1'b1, status, {name, " status"}, rd);
      bus_read(alu_pkg::REG_RESULT, 1'b1, res, {name, " result"}, rd);
      check_irq({name, " done"}, 1'b1);
   endtask

   task automatic run_op(input string name, input alu_pkg::alu_op_e op,
                         input logic [W-1:0] a, input logic [W-1:0] b);
      start_op(name, op, a, b);
      check_op(name, op, a, b);
   endtask

   initial begin
      logic [W-1:0] ra;
      logic [W-1:0] rb;
      logic [W-1:0] rd;
      logic [W-1:0] busy_status;
      clk = 1'b0;
      nrst = 1'b0;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we = 1'b0;
      wb_adr = '0;
      wb_wdat = '0;
      chk_en = 1'b0;
      chk_exp = '0;
      chk_name = "";
      rng = 32'hcaf;
      errors = 0;
      timeouts = 0;
      repeat (16) @(posedge clk);
      nrst <= 1'b1;

      bus_read(alu_pkg::REG_STATUS, 1'b1, '0, "reset status", rd);
      bus_read(alu_pkg::REG_RESULT, 1'b1, '0, "reset result", rd);
      check_irq("reset", 1'b0);

      run_op("add_edge", alu_pkg::OP_ADD, MAX_VAL, 16'sd1);
      run_op("add_edge", alu_pkg::OP_ADD, MIN_VAL, -16'sd1);
      run_op("add_edge", alu_pkg::OP_ADD, MIN_VAL, MAX_VAL);
      run_op("sub_edge", alu_pkg::OP_SUB, MIN_VAL, 16'sd1);
      run_op("sub_edge", alu_pkg::OP_SUB, 16'sd0, MIN_VAL);
      run_op("sub_edge", alu_pkg::OP_SUB, -16'sd1, MAX_VAL);
      for (int i = 0; i < 40; i++) begin
         next_rand(ra);
         next_rand(rb);
         run_op("addsub_rand", (i % 2 == 0) ? alu_pkg::OP_ADD : alu_pkg::OP_SUB, ra, rb);
      end

      run_op("mul_edge", alu_pkg::OP_MUL, MIN_VAL, 16'sd1);
      run_op("mul_edge", alu_pkg::OP_MUL, 16'sd1, MIN_VAL);
      run_op("mul_edge", alu_pkg::OP_MUL, -16'sd128, 16'sd256);  // Exactly the minimum.
      run_op("mul_edge", alu_pkg::OP_MUL, 16'sd128, 16'sd256);
      run_op("mul_edge", alu_pkg::OP_MUL, 16'sd181, -16'sd181);
      run_op("mul_edge", alu_pkg::OP_MUL, -16'sd182, -16'sd182);
      run_op("mul_edge", alu_pkg::OP_MUL, 16'sd0, -16'sd5);
      for (int i = 0; i < 48; i++) begin
         next_rand(ra);
         next_rand(rb);
         if (i % 3 != 2) rb = sext_byte(rb);
         if (i % 3 == 1) ra = sext_byte(ra);
         run_op("mul_rand", alu_pkg::OP_MUL, ra, rb);
      end

      run_op("div_edge", alu_pkg::OP_DIV, -16'sd7, 16'sd2);
      run_op("div_edge", alu_pkg::OP_DIV, 16'sd7, -16'sd2);
      run_op("div_edge", alu_pkg::OP_DIV, -16'sd7, -16'sd2);
      run_op("div_edge", alu_pkg::OP_DIV, 16'sd5, 16'sd0);
      run_op("div_edge", alu_pkg::OP_DIV, MIN_VAL, 16'sd3);
      run_op("div_edge", alu_pkg::OP_DIV, 16'sd3, MIN_VAL);
      run_op("div_edge", alu_pkg::OP_DIV, 16'sd1, MAX_VAL);
      for (int i = 0; i < 40; i++) begin
         next_rand(ra);
         next_rand(rb);
         if (i % 2 == 0) rb = sext_byte(rb);
         if (i % 8 == 3) rb = '0;
         run_op("div_rand", alu_pkg::OP_DIV, ra, rb);
      end

      // A second command while busy must not disturb the running divide.
      busy_status = '0;
      busy_status[alu_pkg::STAT_BUSY] = 1'b1;
      start_op("busy_cmd", alu_pkg::OP_DIV, MAX_VAL, 16'sd3);
      bus_write(alu_pkg::REG_CMD, {{(W-2){1'b0}}, alu_pkg::OP_ADD});
      bus_read(alu_pkg::REG_STATUS, 1'b1, busy_status, "busy_cmd busy", rd);
      check_op("busy_cmd", alu_pkg::OP_DIV, MAX_VAL, 16'sd3);
      bus_read(alu_pkg::REG_CMD, 1'b1, {{(W-2){1'b0}}, alu_pkg::OP_DIV}, "busy_cmd op", rd);
      run_op("irq_clear", alu_pkg::OP_ADD, 16'sd1, 16'sd2);

      finish_run();
   end

endmodule

// File: alu_wb_top.f
logic/alu_pkg.sv
logic/alu_ctrl_if.sv
logic/alu_wb_regs.sv
logic/alu_sequencer.sv
logic/alu_step_counter.sv
logic/alu_datapath.sv
logic/alu_wb_top.sv
verification/alu_wb_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the ALU testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module alu_wb_tb -f alu_wb_top.f \
   || { echo "Build failed"; exit 1; }

out="$(./obj_dir/Valu_wb_tb)"
echo "$out"
echo "$out" | grep -q "Regression passed" && exit 0 || exit 1
